// ==== fix_session.f ====
src/fix_session_pkg.sv
src/session_state_ram.sv
src/host_table.sv
src/session_manager.sv
src/msg_order_gen.sv
src/fix_session_top.sv
tests/session_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the session layer testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f fix_session.f --top-module session_tb \
	-o session_sim && \
	./obj_dir/session_sim | tee /dev/stderr | grep -qF "PASS: all tests" && \
	echo "simulation passed" || { echo "simulation failed"; exit 1; }

// ==== tests/session_input.txt ====
# op host a b act send type cid, all hex, one step per cycle
# op 1 load (a=initiator b=comp_len cid), 2 msg (a=type b=validity), 3 conn, 4 end, 5 tmo, 6 rsnd done
# act bits 0 disconnect 1 ignore 2 do_resend 3 seq_update; type is the expected order type
1 0 1 6 0 0 0 42524f4b45520000
1 1 0 5 0 0 0 4558434847000000
1 2 0 4 0 0 0 4445534b00000000
1 3 1 8 0 0 0 434c454152494e47
1 4 1 3 0 0 0 4f4d530000000000
# initiator host 0 logs on, gets a reply, then heartbeats
3 0 0 0 0 1 1 0
2 0 1 0 0 0 0 0
2 0 3 0 0 1 3 0
2 0 7 0 0 0 0 0
# acceptor hosts 1 and 2
3 1 0 0 0 0 0 0
2 1 1 0 0 1 1 0
3 2 0 0 0 0 0 0
2 2 7 0 1 0 0 0
# timeouts on host 0, seq_low on host 3
5 0 0 0 0 1 3 0
5 0 0 0 1 0 0 0
3 3 0 0 0 1 1 0
2 3 1 0 0 0 0 0
2 3 7 2 1 0 0 0
# gap on logout, gap fill, resend done and closing logout on host 1
2 1 2 3 0 1 4 0
2 1 5 0 8 0 0 0
2 1 7 3 0 1 4 0
6 1 0 0 0 1 2 0
2 1 2 0 1 0 0 0
# garbled and resend requests on host 4
3 4 0 0 0 1 1 0
2 4 3 1 2 0 0 0
2 4 1 0 0 0 0 0
2 4 7 1 2 0 0 0
2 4 4 0 4 0 0 0
# hosts 0 and 3 alternating on back to back cycles
3 0 0 0 0 1 1 0
3 3 0 0 0 1 1 0
2 0 1 0 0 0 0 0
2 3 1 3 0 1 4 0
5 0 0 0 0 1 3 0
6 3 0 0 0 0 0 0
2 0 2 0 0 1 2 0
4 3 0 0 0 1 2 0
2 3 4 0 4 0 0 0
5 3 0 0 1 0 0 0
2 0 3 0 0 0 0 0
# garbled first message on an acceptor disconnects
3 2 0 0 0 0 0 0
2 2 1 1 1 0 0 0

// ==== tests/session_tb.sv ====
/* testbench for the FIX session layer
   replays the steps of the input file, one per cycle, back to back
   checks actions, message orders and the initiate strobe count */
module session_tb import fix_session_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int HOST_BITS   = 3;
	localparam int READY_LIMIT = 64;
	localparam string STEP_FILE = "tests/session_input.txt";

	// step kinds from the first column of the input file
	localparam logic [3:0] OP_LOAD        = 4'd1;
	localparam logic [3:0] OP_NEW_MSG     = 4'd2;
	localparam logic [3:0] OP_CONNECTED   = 4'd3;
	localparam logic [3:0] OP_END_SESSION = 4'd4;
	localparam logic [3:0] OP_TIMEOUT     = 4'd5;
	localparam logic [3:0] OP_RESEND_DONE = 4'd6;

	// session actions seen one cycle after an event
	typedef struct packed {
		logic                 disconnect;
		logic [HOST_BITS-1:0] disconnect_host;
		logic                 ignore;
		logic                 do_resend;
		logic                 seq_update;
		logic [HOST_BITS-1:0] seq_host;
	} action_t;

	typedef struct packed {
		logic [3:0]           op;
		logic [HOST_BITS-1:0] host;
		rx_msg_t              rx_msg;
		host_entry_t          entry;
		action_t              exp_act;
		logic                 exp_send;
		msg_order_t           exp_order;
	} step_t;

	logic                 clk;
	logic                 rst;
	logic                 new_msg;
	rx_msg_t              rx_msg;
	logic                 connected_ev;
	logic                 end_session;
	logic                 timeout;
	logic                 resend_done;
	logic [HOST_BITS-1:0] host;
	logic                 host_wr;
	logic [HOST_BITS-1:0] host_wr_addr;
	host_entry_t          host_entry;
	logic                 disconnect;
	logic [HOST_BITS-1:0] disconnect_host;
	logic                 ignore;
	logic                 do_resend;
	logic                 seq_update;
	logic [HOST_BITS-1:0] seq_host;
	logic                 initiate_msg;
	msg_order_t           msg_order;
	logic                 ready;

	step_t steps [$];
	string step_names [$];
	int    sends_expected;

	fix_session_top #(.HOST_BITS(HOST_BITS)) dut0 (
		.clk               (clk),
		.rst               (rst),
		.new_msg_i         (new_msg),
		.rx_msg_i          (rx_msg),
		.connected_i       (connected_ev),
		.end_session_i     (end_session),
		.timeout_i         (timeout),
		.resend_done_i     (resend_done),
		.host_i            (host),
		.host_wr_i         (host_wr),
		.host_wr_addr_i    (host_wr_addr),
		.host_entry_i      (host_entry),
		.disconnect_o      (disconnect),
		.disconnect_host_o (disconnect_host),
		.ignore_o          (ignore),
		.do_resend_o       (do_resend),
		.seq_update_o      (seq_update),
		.seq_host_o        (seq_host),
		.initiate_msg_o    (initiate_msg),
		.msg_order_o       (msg_order),
		.ready_o           (ready)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic end_with_failure();
		$display("FAIL: see errors above");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic drive_step(input step_t s);
		new_msg      <= (s.op == OP_NEW_MSG);
		connected_ev <= (s.op == OP_CONNECTED);
		end_session  <= (s.op == OP_END_SESSION);
		timeout      <= (s.op == OP_TIMEOUT);
		resend_done  <= (s.op == OP_RESEND_DONE);
		host_wr      <= (s.op == OP_LOAD);
		host         <= s.host;
		host_wr_addr <= s.host;
		rx_msg       <= s.rx_msg;
		host_entry   <= s.entry;
	endtask

	function automatic string action_text(input action_t a);
		return $sformatf("disc=%b/%0d ign=%b rsnd=%b seq=%b/%0d", a.disconnect,
			a.disconnect_host, a.ignore, a.do_resend, a.seq_update, a.seq_host);
	endfunction

	function automatic string order_text(input msg_order_t o);
		return $sformatf("type=%0d len=%0d id=%h", o.msg_type, o.comp_len, o.target_comp_id);
	endfunction

	task automatic check_action(input string name, input action_t exp);
		action_t act;
		act.disconnect      = disconnect;
		act.disconnect_host = disconnect_host;
		act.ignore          = ignore;
		act.do_resend       = do_resend;
		act.seq_update      = seq_update;
		act.seq_host        = seq_host;
		if (act !== exp) begin
			$display("[ERROR] %s actions: expected %s, actual %s", name,
				action_text(exp), action_text(act));
			end_with_failure();
		end
	endtask

	task automatic check_order(input string name, input logic exp_send, input msg_order_t exp);
		if (initiate_msg !== exp_send) begin
			$display("[ERROR] %s initiate: expected %b, actual %b", name, exp_send,
				initiate_msg);
			end_with_failure();
		end
		if (exp_send && msg_order !== exp) begin
			$display("[ERROR] %s order: expected %s, actual %s", name,
				order_text(exp), order_text(msg_order));
			end_with_failure();
		end
	endtask

	task automatic check_state_path(input string name, input int exp_count, input int act_count);
		if (act_count != exp_count) begin
			$display("[ERROR] %s: expected %0d, actual %0d", name, exp_count, act_count);
			end_with_failure();
		end
	endtask

	// parses the step file and mirrors the host table for the expected orders
	task automatic load_steps();
		int          fd;
		int          n;
		int          line_no;
		string       line;
		logic [63:0] f_op, f_host, f_a, f_b, f_act, f_send, f_type, f_cid;
		step_t       s;
		host_entry_t mirror [2**HOST_BITS];
		foreach (mirror[i])
			mirror[i] = '0;
		sends_expected = 0;
		line_no = 0;
		fd = $fopen(STEP_FILE, "r");
		if (fd == 0) begin
			$display("could not open the step file %s", STEP_FILE);
			end_with_failure();
		end
		while ($fgets(line, fd) != 0) begin
			line_no++;
			n = $sscanf(line, "%h %h %h %h %h %h %h %h",
				f_op, f_host, f_a, f_b, f_act, f_send, f_type, f_cid);
			if (n == 8) begin
				s      = '0;
				s.op   = f_op[3:0];
				s.host = f_host[HOST_BITS-1:0];
				if (s.op == OP_LOAD) begin
					s.entry.initiator      = f_a[0];
					s.entry.comp_len       = f_b[COMP_LEN_W-1:0];
					s.entry.target_comp_id = f_cid;
					mirror[s.host]         = s.entry;
				end else begin
					s.rx_msg.msg_type = msg_type_e'(f_a[3:0]);
					s.rx_msg.validity = validity_e'(f_b[3:0]);
				end
				s.exp_act.disconnect      = f_act[0];
				s.exp_act.disconnect_host = f_act[0] ? s.host : '0;
				s.exp_act.ignore          = f_act[1];
				s.exp_act.do_resend       = f_act[2];
				s.exp_act.seq_update      = f_act[3];
				s.exp_act.seq_host        = f_act[3] ? s.host : '0;
				s.exp_send                = f_send[0];
				s.exp_order.msg_type       = msg_type_e'(f_type[3:0]);
				s.exp_order.comp_len       = mirror[s.host].comp_len;
				s.exp_order.target_comp_id = mirror[s.host].target_comp_id;
				if (s.exp_send)
					sends_expected++;
				steps.push_back(s);
				step_names.push_back($sformatf("step %0d (line %0d)", steps.size(), line_no));
			end else if (n > 0) begin
				$display("line %0d of the step file has %0d fields instead of 8", line_no, n);
				end_with_failure();
			end
		end
		$fclose(fd);
	endtask

	initial begin
		int wait_cycles;
		int strobe_count;
		rst <= 1'b1;
		drive_step('0);
		load_steps();
		repeat (4) @(posedge clk);
		rst <= 1'b0;

		// state table sweep takes one cycle per host
		wait_cycles = 0;
		@(negedge clk);
		while (!ready && wait_cycles < READY_LIMIT) begin
			@(negedge clk);
			wait_cycles++;
		end
		if (!ready) begin
			$display("the session state table never finished clearing after reset");
			end_with_failure();
		end

		// actions lag one cycle and orders two
		strobe_count = 0;
		for (int c = 0; c < steps.size() + 2; c++) begin
			@(posedge clk);
			if (c < steps.size())
				drive_step(steps[c]);
			else
				drive_step('0);
			@(negedge clk);
			if (initiate_msg)
				strobe_count++;
			if (c >= 1 && c <= steps.size())
				check_action(step_names[c-1], steps[c-1].exp_act);
			if (c >= 2)
				check_order(step_names[c-2], steps[c-2].exp_send, steps[c-2].exp_order);
		end
		check_state_path("initiate strobe count", sends_expected, strobe_count);
		$display("PASS: all tests");
		$finish;
	end

endmodule

// ==== src/fix_session_top.sv ====
/* top level of the FIX session layer
   host table, session manager and message order stage */
module fix_session_top import fix_session_pkg::*; #(
	parameter int HOST_BITS = 3
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 new_msg_i,
	input  rx_msg_t              rx_msg_i,
	input  logic                 connected_i,
	input  logic                 end_session_i,
	input  logic                 timeout_i,
	input  logic                 resend_done_i,
	input  logic [HOST_BITS-1:0] host_i,
	input  logic                 host_wr_i,
	input  logic [HOST_BITS-1:0] host_wr_addr_i,
	input  host_entry_t          host_entry_i,
	output logic                 disconnect_o,
	output logic [HOST_BITS-1:0] disconnect_host_o,
	output logic                 ignore_o,
	output logic                 do_resend_o,
	output logic                 seq_update_o,
	output logic [HOST_BITS-1:0] seq_host_o,
	output logic                 initiate_msg_o,
	output msg_order_t           msg_order_o,
	output logic                 ready_o
);

	logic [HOST_BITS-1:0] host_rd_addr;
	host_entry_t          host_entry_rd;
	logic                 send_req;
	msg_order_t           send_order;

	host_table #(.HOST_BITS(HOST_BITS)) u_host_table (
		.clk       (clk),
		.wr_i      (host_wr_i),
		.wr_addr_i (host_wr_addr_i),
		.entry_i   (host_entry_i),
		.rd_addr_i (host_rd_addr),
		.entry_o   (host_entry_rd)
	);

	session_manager #(.HOST_BITS(HOST_BITS)) u_session_manager (
		.clk               (clk),
		.rst               (rst),
		.new_msg_i         (new_msg_i),
		.rx_msg_i          (rx_msg_i),
		.connected_i       (connected_i),
		.end_session_i     (end_session_i),
		.timeout_i         (timeout_i),
		.resend_done_i     (resend_done_i),
		.host_i            (host_i),
		.host_entry_i      (host_entry_rd),
		.host_rd_addr_o    (host_rd_addr),
		.disconnect_o      (disconnect_o),
		.disconnect_host_o (disconnect_host_o),
		.ignore_o          (ignore_o),
		.do_resend_o       (do_resend_o),
		.seq_update_o      (seq_update_o),
		.seq_host_o        (seq_host_o),
		.send_req_o        (send_req),
		.send_order_o      (send_order),
		.ready_o           (ready_o)
	);

	msg_order_gen u_msg_order_gen (
		.clk            (clk),
		.rst            (rst),
		.send_req_i     (send_req),
		.send_order_i   (send_order),
		.initiate_msg_o (initiate_msg_o),
		.msg_order_o    (msg_order_o)
	);

endmodule

// ==== src/msg_order_gen.sv ====
/* message order stage
   one send request becomes an order and an initiate strobe for the builder */
module msg_order_gen import fix_session_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       send_req_i,
	input  msg_order_t send_order_i,
	output logic       initiate_msg_o,
	output msg_order_t msg_order_o
);

	// strobe, one per accepted order
	always_ff @(posedge clk) begin
		if (rst)
			initiate_msg_o <= 1'b0;
		else
			initiate_msg_o <= send_req_i;
	end

	// builder may sample the order after the strobe
	always_ff @(posedge clk) begin
		if (send_req_i)
			msg_order_o <= send_order_i;
	end

	// every order names a real session message
	a_typed_order: assert property (@(posedge clk) disable iff (rst)
		initiate_msg_o |-> msg_order_o.msg_type != none);

endmodule

// ==== src/session_manager.sv ====
/* FIX session state machine
   decodes one event per cycle against the host's stored state
   registers the action pulses and the send order, writes the state back */
module session_manager import fix_session_pkg::*; #(
	parameter int HOST_BITS = 3
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 new_msg_i,
	input  rx_msg_t              rx_msg_i,
	input  logic                 connected_i,
	input  logic                 end_session_i,
	input  logic                 timeout_i,
	input  logic                 resend_done_i,
	input  logic [HOST_BITS-1:0] host_i,
	input  host_entry_t          host_entry_i,
	output logic [HOST_BITS-1:0] host_rd_addr_o,
	output logic                 disconnect_o,
	output logic [HOST_BITS-1:0] disconnect_host_o,
	output logic                 ignore_o,
	output logic                 do_resend_o,
	output logic                 seq_update_o,
	output logic [HOST_BITS-1:0] seq_host_o,
	output logic                 send_req_o,
	output msg_order_t           send_order_o,
	output logic                 ready_o
);

	session_state_e cur_state, nxt_state;
	msg_type_e      rx_type, send_type;
	validity_e      rx_val;
	logic           ev_any, st_we, ram_busy;
	logic           act_disc, act_ignore, act_resend, act_seq, act_send;

	session_state_ram #(.HOST_BITS(HOST_BITS)) u_state_ram (
		.clk     (clk),
		.rst     (rst),
		.we_i    (st_we),
		.addr_i  (host_i),
		.state_i (nxt_state),
		.state_o (cur_state),
		.busy_o  (ram_busy)
	);

	assign host_rd_addr_o = host_i;
	assign ready_o        = !ram_busy;
	assign rx_type        = rx_msg_i.msg_type;
	assign rx_val         = rx_msg_i.validity;
	assign ev_any  = new_msg_i | connected_i | end_session_i | timeout_i | resend_done_i;
	assign st_we    = ev_any && (nxt_state != cur_state);
	assign act_send = (send_type != none);

	always_comb begin
		nxt_state  = cur_state;
		send_type  = none;
		act_disc   = 1'b0;
		act_ignore = 1'b0;
		act_resend = 1'b0;
		act_seq    = 1'b0;
		if (new_msg_i) begin
			if (cur_state == disconnected) begin
				// nothing to talk to
			end else if (rx_val == garbled && cur_state != connected) begin
				act_ignore = 1'b1;
			end else if (rx_val == seq_low || rx_val == invalid) begin
				act_disc  = 1'b1;
				nxt_state = disconnected;
			end else begin
				case (cur_state)
					connected: begin // acceptor expects a logon first
						if (rx_type == logon && rx_val == valid) begin
							send_type = logon;
							nxt_state = normal_session;
						end else begin
							act_disc  = 1'b1;
							nxt_state = disconnected;
						end
					end
					logon_sent: begin
						if (rx_type == logon && rx_val == valid) begin
							nxt_state = normal_session;
						end else if (rx_type == logon && rx_val == seq_high) begin
							send_type = resend_req;
							nxt_state = sent_resend_req;
						end else begin
							act_disc  = 1'b1;
							nxt_state = disconnected;
						end
					end
					normal_session, sent_heartbeat: begin
						if (rx_type == logout && rx_val == valid) begin
							send_type = logout; // answer and close
							nxt_state = disconnected;
						end else if (rx_type == logout && rx_val == seq_high) begin
							send_type = resend_req;
							nxt_state = resend_req_logout;
						end else if (rx_type == resend_req) begin
							act_resend = 1'b1;
						end else if (rx_val == seq_high) begin
							send_type = resend_req;
							nxt_state = sent_resend_req;
						end else if (cur_state == sent_heartbeat) begin
							nxt_state = normal_session; // peer is alive
						end else if (rx_type == heartbeat) begin
							send_type = heartbeat;
							nxt_state = sent_heartbeat;
						end
					end
					sent_resend_req, resend_req_logout: begin
						if (rx_type == gap_fill || rx_type == seq_reset)
							act_seq = 1'b1;
						else if (rx_val == seq_high)
							send_type = resend_req; // gap widened so ask again
					end
					logout_sent: begin
						if (rx_type == resend_req) begin
							act_resend = 1'b1;
						end else begin
							act_disc  = 1'b1; // logout reply or anything else
							nxt_state = disconnected;
						end
					end
					default: ;
				endcase
			end
		end else if (connected_i) begin
			if (host_entry_i.initiator) begin
				send_type = logon;
				nxt_state = logon_sent;
			end else begin
				nxt_state = connected;
			end
		end else if (end_session_i) begin
			send_type = logout;
			nxt_state = logout_sent;
		end else if (timeout_i) begin
			if (cur_state == logon_sent || cur_state == logout_sent ||
			    cur_state == sent_heartbeat) begin
				act_disc  = 1'b1; // no answer in time
				nxt_state = disconnected;
			end else if (cur_state == normal_session) begin
				send_type = heartbeat;
				nxt_state = sent_heartbeat;
			end
		end else if (resend_done_i) begin
			if (cur_state == sent_resend_req) begin
				nxt_state = normal_session;
			end else if (cur_state == resend_req_logout) begin
				send_type = logout;
				nxt_state = logout_sent;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			disconnect_o      <= 1'b0;
			disconnect_host_o <= '0;
			ignore_o          <= 1'b0;
			do_resend_o       <= 1'b0;
			seq_update_o      <= 1'b0;
			seq_host_o        <= '0;
			send_req_o        <= 1'b0;
		end else begin
			disconnect_o      <= act_disc;
			disconnect_host_o <= act_disc ? host_i : '0;
			ignore_o          <= act_ignore;
			do_resend_o       <= act_resend;
			seq_update_o      <= act_seq;
			seq_host_o        <= act_seq ? host_i : '0;
			send_req_o        <= act_send;
		end
	end

	// order payload held until the next send
	always_ff @(posedge clk) begin
		if (act_send) begin
			send_order_o.msg_type       <= send_type;
			send_order_o.comp_len       <= host_entry_i.comp_len;
			send_order_o.target_comp_id <= host_entry_i.target_comp_id;
		end
	end

	a_one_event: assert property (@(posedge clk) disable iff (rst)
		$onehot0({new_msg_i, connected_i, end_session_i, timeout_i, resend_done_i}));

endmodule

// ==== src/host_table.sv ====
/* host address table
   target CompID, its length and the initiator flag per host
   loaded through the write port, read combinationally */
module host_table import fix_session_pkg::*; #(
	parameter int HOST_BITS = 3
) (
	input  logic                 clk,
	input  logic                 wr_i,
	input  logic [HOST_BITS-1:0] wr_addr_i,
	input  host_entry_t          entry_i,
	input  logic [HOST_BITS-1:0] rd_addr_i,
	output host_entry_t          entry_o
);

	host_entry_t table_q [2**HOST_BITS];

	// loaded once by the host CPU before the sessions start
	always_ff @(posedge clk) begin
		if (wr_i)
			table_q[wr_addr_i] <= entry_i;
	end

	assign entry_o = table_q[rd_addr_i]; // same cycle as the event

endmodule

// ==== src/session_state_ram.sv ====
/* session state memory, one entry per host
   synchronous write, combinational read, swept to disconnected after reset */
module session_state_ram import fix_session_pkg::*; #(
	parameter int HOST_BITS = 3
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 we_i,
	input  logic [HOST_BITS-1:0] addr_i,
	input  session_state_e       state_i,
	output session_state_e       state_o,
	output logic                 busy_o
);

	session_state_e mem [2**HOST_BITS];
	logic [HOST_BITS-1:0] sweep_cnt;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy_o    <= 1'b1;
			sweep_cnt <= '0;
		end else if (busy_o) begin
			sweep_cnt <= sweep_cnt + 1'b1;
			if (&sweep_cnt)
				busy_o <= 1'b0; // last host cleared
		end
	end

	always_ff @(posedge clk) begin
		if (busy_o)
			mem[sweep_cnt] <= disconnected;
		else if (we_i)
			mem[addr_i] <= state_i;
	end

	assign state_o = mem[addr_i];

	// the session manager must stay quiet until the sweep is over
	a_no_write_in_sweep: assert property (@(posedge clk) disable iff (rst) busy_o |-> !we_i);

endmodule

// ==== src/fix_session_pkg.sv ====
/* shared definitions for the FIX session layer
   session state, message type and validity encodings
   CompID widths, host entry, received message and message order structs */
package fix_session_pkg;

	localparam int COMP_ID_W  = 64; // eight characters
	localparam int COMP_LEN_W = 4;  // significant bytes in the CompID

	// per-host session state
	typedef enum logic [3:0] {
		disconnected      = 4'd0,
		connected         = 4'd1,  // acceptor waiting for logon
		logon_sent        = 4'd2,  // initiator waiting for logon reply
		normal_session    = 4'd3,
		sent_heartbeat    = 4'd4,
		logout_sent       = 4'd5,
		sent_resend_req   = 4'd6,
		resend_req_logout = 4'd7   // resend pending, logout follows
	} session_state_e;

	// session message types, both directions
	typedef enum logic [3:0] {
		none       = 4'd0,
		logon      = 4'd1,
		logout     = 4'd2,
		heartbeat  = 4'd3,
		resend_req = 4'd4,
		gap_fill   = 4'd5,
		seq_reset  = 4'd6,
		app_msg    = 4'd7
	} msg_type_e;

	// verdict of the receive path on one message
	typedef enum logic [3:0] {
		valid    = 4'd0,
		garbled  = 4'd1,
		seq_low  = 4'd2, // fatal
		seq_high = 4'd3, // gap, ask for resend
		invalid  = 4'd4
	} validity_e;

	// one host address table entry
	typedef struct packed {
		logic                  initiator;      // 1 = we open the session
		logic [COMP_LEN_W-1:0] comp_len;
		logic [COMP_ID_W-1:0]  target_comp_id;
	} host_entry_t;

	typedef struct packed {
		msg_type_e msg_type;
		validity_e validity;
	} rx_msg_t;

	// order to the message builder
	typedef struct packed {
		msg_type_e             msg_type;
		logic [COMP_LEN_W-1:0] comp_len;
		logic [COMP_ID_W-1:0]  target_comp_id;
	} msg_order_t;

endpackage
